// ==== periph_pkg.sv ====
/*
  Bus types, address map and target select codes shared by the peripheral
  subsystem. Every block imports what it needs from this package.
*/
package periph_pkg;

  // ----------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [1:0]  sel_t;

  // Target select codes
  localparam sel_t SelErr     = 2'd0;
  localparam sel_t SelSram    = 2'd1;
  localparam sel_t SelSocCtrl = 2'd2;
  localparam sel_t SelGpio    = 2'd3;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam addr_t SramBaseAddr    = 32'h1000_0000;
  localparam addr_t SocCtrlBaseAddr = 32'h0300_0000;
  localparam addr_t GpioBaseAddr    = 32'h0300_5000;

  // Register offset width inside a 4 KiB peripheral window
  localparam int unsigned PeriphWinBits = 12;

  // Marker returned on unmapped accesses
  localparam data_t ErrRspData = 32'hBADC_AB1E;

  // Replace the enabled bytes of a register word
  function automatic data_t merge_be(data_t old_word, data_t new_word, be_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

// ==== periph_demux.sv ====
/*
  Address decoder and response router for the single bus manager.
  The request goes to one target in the same cycle; the registered select
  code picks that target's response in the following cycle.
*/
`timescale 1ns/1ps

module periph_demux #(
  parameter int unsigned SramNumWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic              err_o,
  output periph_pkg::data_t rdata_o,
  output logic              sram_req_o,
  output logic              soc_ctrl_req_o,
  output logic              gpio_req_o,
  output logic              err_req_o,
  input  logic              sram_rvalid_i,
  input  logic              soc_ctrl_rvalid_i,
  input  logic              gpio_rvalid_i,
  input  logic              err_rvalid_i,
  input  periph_pkg::data_t sram_rdata_i,
  input  periph_pkg::data_t soc_ctrl_rdata_i,
  input  periph_pkg::data_t gpio_rdata_i,
  input  periph_pkg::data_t err_rdata_i,
  input  logic              err_err_i
);
  import periph_pkg::*;

  localparam addr_t SramEndAddr = SramBaseAddr + addr_t'(SramNumWords * 4);

  sel_t       sel_d;
  sel_t       sel_q;
  logic [3:0] tgt_req;
  logic [3:0] tgt_rvalid;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  always_comb begin
    if (addr_i >= SramBaseAddr && addr_i < SramEndAddr) begin
      sel_d = SelSram;
    end else if (addr_i[31:PeriphWinBits] == SocCtrlBaseAddr[31:PeriphWinBits]) begin
      sel_d = SelSocCtrl;
    end else if (addr_i[31:PeriphWinBits] == GpioBaseAddr[31:PeriphWinBits]) begin
      sel_d = SelGpio;
    end else begin
      sel_d = SelErr;
    end
  end

  // All targets accept every cycle
  assign gnt_o = req_i;

  // One-hot strobe indexed by select code
  assign tgt_req        = req_i ? (4'b0001 << sel_d) : 4'b0000;
  assign err_req_o      = tgt_req[SelErr];
  assign sram_req_o     = tgt_req[SelSram];
  assign soc_ctrl_req_o = tgt_req[SelSocCtrl];
  assign gpio_req_o     = tgt_req[SelGpio];

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= SelErr;
    end else if (req_i) begin
      sel_q <= sel_d;
    end
  end

  assign tgt_rvalid = {gpio_rvalid_i, soc_ctrl_rvalid_i, sram_rvalid_i, err_rvalid_i};
  assign rvalid_o   = tgt_rvalid[sel_q];

  always_comb begin
    case (sel_q)
      SelSram:    rdata_o = sram_rdata_i;
      SelSocCtrl: rdata_o = soc_ctrl_rdata_i;
      SelGpio:    rdata_o = gpio_rdata_i;
      default:    rdata_o = err_rdata_i;
    endcase
  end

  // Only the error subordinate ever flags an error
  assign err_o = (sel_q == SelErr) && err_err_i;

  // Each target answers exactly one cycle after its strobe
  a_tgt_rsp_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_rvalid == $past(tgt_req))
    else $error("target rvalid does not follow its request by one cycle");

endmodule

// ==== periph_err_sbr.sv ====
/*
  Error subordinate for unmapped addresses. Every request is answered one
  cycle later with the error flag set and a fixed marker word.
*/
`timescale 1ns/1ps

module periph_err_sbr (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  output logic              rvalid_o,
  output logic              err_o,
  output periph_pkg::data_t rdata_o
);
  import periph_pkg::*;

  logic rvalid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q;
  // Marker only while answering
  assign rdata_o  = rvalid_q ? ErrRspData : '0;

endmodule

// ==== sram_bank.sv ====
/*
  Single-port word memory behind the SRAM window. Writes honour byte
  enables; reads return the addressed word one cycle after the request.
*/
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned SramNumWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::be_t   be_i,
  output logic              rvalid_o,
  output periph_pkg::data_t rdata_o
);
  import periph_pkg::*;

  localparam int unsigned IdxBits = $clog2(SramNumWords);

  typedef logic [IdxBits-1:0] idx_t;

  addr_t word_off;
  idx_t  word_idx;
  data_t mem_q [SramNumWords];
  data_t rdata_q;
  logic  rvalid_q;

  // Word offset from the window base
  assign word_off = (addr_i - SramBaseAddr) >> 2;
  assign word_idx = word_off[IdxBits-1:0];

  // Storage and read port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (req_i && !we_i) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // Decoder must never route an address past the end of the bank
  a_idx_in_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> (word_off < SramNumWords))
    else $error("SRAM request outside the bank, word offset %0d", word_off);

endmodule

// ==== soc_ctrl_regs.sv ====
/*
  SoC control registers: boot address, fetch enable and a scratch word.
  The boot address and fetch enable feed the core start-up logic.
*/
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::be_t   be_i,
  input  logic              fetch_en_i,
  output logic              rvalid_o,
  output periph_pkg::data_t rdata_o,
  output periph_pkg::addr_t boot_addr_o,
  output logic              fetch_enable_o
);
  import periph_pkg::*;

  typedef logic [PeriphWinBits-1:0] off_t;

  localparam off_t OffBootAddr = off_t'('h0);
  localparam off_t OffFetchEn  = off_t'('h4);
  localparam off_t OffScratch  = off_t'('h8);

  off_t  reg_off;
  logic  wr_en;
  logic  rd_en;
  addr_t bootaddr_q;
  logic  fetchen_q;
  data_t scratch_q;
  data_t rd_word;
  data_t rdata_q;
  logic  rvalid_q;

  assign reg_off = addr_i[PeriphWinBits-1:0];
  assign wr_en   = req_i & we_i;
  assign rd_en   = req_i & ~we_i;

  // ----------------------------------------------------------
  // Register file
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bootaddr_q <= SramBaseAddr;
      fetchen_q  <= 1'b0;
      scratch_q  <= '0;
    end else if (wr_en) begin
      case (reg_off)
        OffBootAddr: bootaddr_q <= merge_be(bootaddr_q, wdata_i, be_i);
        OffFetchEn: begin
          if (be_i[0]) begin
            fetchen_q <= wdata_i[0];
          end
        end
        OffScratch:  scratch_q <= merge_be(scratch_q, wdata_i, be_i);
        default:     ;
      endcase
    end
  end

  // Read mux, unknown offsets give zero
  always_comb begin
    case (reg_off)
      OffBootAddr: rd_word = bootaddr_q;
      OffFetchEn:  rd_word = {31'd0, fetchen_q};
      OffScratch:  rd_word = scratch_q;
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o       = rvalid_q;
  assign rdata_o        = rdata_q;
  assign boot_addr_o    = bootaddr_q;
  assign fetch_enable_o = fetchen_q | fetch_en_i;

endmodule

// ==== gpio_ctrl.sv ====
/*
  GPIO block with direction, output and interrupt enable registers, a
  two-flop input synchronizer and rising-edge interrupts with W1C status.
*/
`timescale 1ns/1ps

module gpio_ctrl #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  periph_pkg::addr_t    addr_i,
  input  periph_pkg::data_t    wdata_i,
  input  periph_pkg::be_t      be_i,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 gpio_irq_o,
  output logic                 rvalid_o,
  output periph_pkg::data_t    rdata_o
);
  import periph_pkg::*;

  typedef logic [GpioCount-1:0]     pins_t;
  typedef logic [PeriphWinBits-1:0] off_t;

  localparam off_t OffDir       = off_t'('h00);
  localparam off_t OffOut       = off_t'('h04);
  localparam off_t OffIn        = off_t'('h08);
  localparam off_t OffIrqEn     = off_t'('h0C);
  localparam off_t OffIrqStatus = off_t'('h10);

  off_t  reg_off;
  logic  wr_en;
  pins_t dir_q, out_q, irq_en_q, irq_status_q;
  pins_t in_meta_q, in_sync_q, in_prev_q;
  pins_t rise, status_clr;
  data_t rd_word, rdata_q;
  logic  rvalid_q;

  assign reg_off = addr_i[PeriphWinBits-1:0];
  assign wr_en   = req_i & we_i;

  // ----------------------------------------------------------
  // Input synchronizer and edge detect
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  assign rise = in_sync_q & ~in_prev_q;

  // Enabled bytes of wdata select the bits to clear
  assign status_clr = (wr_en && reg_off == OffIrqStatus) ?
                      pins_t'(merge_be('0, wdata_i, be_i)) : '0;

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
    end else if (wr_en) begin
      case (reg_off)
        OffDir:   dir_q    <= pins_t'(merge_be(data_t'(dir_q), wdata_i, be_i));
        OffOut:   out_q    <= pins_t'(merge_be(data_t'(out_q), wdata_i, be_i));
        OffIrqEn: irq_en_q <= pins_t'(merge_be(data_t'(irq_en_q), wdata_i, be_i));
        default:  ;
      endcase
    end
  end

  // A new edge wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_status_q <= '0;
    end else begin
      irq_status_q <= (irq_status_q & ~status_clr) | (rise & irq_en_q);
    end
  end

  always_comb begin
    case (reg_off)
      OffDir:       rd_word = data_t'(dir_q);
      OffOut:       rd_word = data_t'(out_q);
      OffIn:        rd_word = data_t'(in_sync_q);
      OffIrqEn:     rd_word = data_t'(irq_en_q);
      OffIrqStatus: rd_word = data_t'(irq_status_q);
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= rd_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o       = rvalid_q;
  assign rdata_o        = rdata_q;
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = in_sync_q;
  assign gpio_irq_o     = |irq_status_q;

endmodule

// ==== periph_subsystem.sv ====
/*
  Memory and peripheral side of the SoC domain. One OBI-style manager port
  reaches the SRAM bank, SoC control, GPIO and the error subordinate.
*/
`timescale 1ns/1ps

module periph_subsystem #(
  parameter int unsigned GpioCount    = 16,
  parameter int unsigned SramNumWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic                 fetch_en_i,
  input  periph_pkg::addr_t    addr_i,
  input  periph_pkg::data_t    wdata_i,
  input  periph_pkg::be_t      be_i,
  input  logic [GpioCount-1:0] gpio_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic                 err_o,
  output logic                 fetch_enable_o,
  output logic                 gpio_irq_o,
  output periph_pkg::data_t    rdata_o,
  output periph_pkg::addr_t    boot_addr_o,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o
);
  import periph_pkg::*;

  // ----------------------------------------------------------
  // Per-target strobes and responses
  // ----------------------------------------------------------
  logic  sram_req, soc_ctrl_req, gpio_req, err_req;
  logic  sram_rvalid, soc_ctrl_rvalid, gpio_rvalid, err_rvalid;
  data_t sram_rdata, soc_ctrl_rdata, gpio_rdata, err_rdata;
  logic  err_err;

  periph_demux #(
    .SramNumWords ( SramNumWords )
  ) i_demux (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .gnt_o,
    .rvalid_o,
    .err_o,
    .rdata_o,
    .sram_req_o        ( sram_req        ),
    .soc_ctrl_req_o    ( soc_ctrl_req    ),
    .gpio_req_o        ( gpio_req        ),
    .err_req_o         ( err_req         ),
    .sram_rvalid_i     ( sram_rvalid     ),
    .soc_ctrl_rvalid_i ( soc_ctrl_rvalid ),
    .gpio_rvalid_i     ( gpio_rvalid     ),
    .err_rvalid_i      ( err_rvalid      ),
    .sram_rdata_i      ( sram_rdata      ),
    .soc_ctrl_rdata_i  ( soc_ctrl_rdata  ),
    .gpio_rdata_i      ( gpio_rdata      ),
    .err_rdata_i       ( err_rdata       ),
    .err_err_i         ( err_err         )
  );

  periph_err_sbr i_err_sbr (
    .clk_i,
    .rst_n_i,
    .req_i    ( err_req    ),
    .rvalid_o ( err_rvalid ),
    .err_o    ( err_err    ),
    .rdata_o  ( err_rdata  )
  );

  sram_bank #(
    .SramNumWords ( SramNumWords )
  ) i_sram (
    .clk_i,
    .rst_n_i,
    .req_i    ( sram_req    ),
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .rvalid_o ( sram_rvalid ),
    .rdata_o  ( sram_rdata  )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .req_i    ( soc_ctrl_req    ),
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .fetch_en_i,
    .rvalid_o ( soc_ctrl_rvalid ),
    .rdata_o  ( soc_ctrl_rdata  ),
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_ctrl #(
    .GpioCount ( GpioCount )
  ) i_gpio (
    .clk_i,
    .rst_n_i,
    .req_i    ( gpio_req    ),
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .gpio_irq_o,
    .rvalid_o ( gpio_rvalid ),
    .rdata_o  ( gpio_rdata  )
  );

endmodule

// ==== tb_periph_subsystem.sv ====
/*
  Testbench for the peripheral subsystem. Drives the OBI-style manager port
  through SRAM, SoC control, GPIO and unmapped accesses, and checks every
  response against an expected queue built from the address map.
*/
`timescale 1ns/1ps

module tb_periph_subsystem;
  import periph_pkg::*;

  localparam int unsigned GpioCount    = 16;
  localparam int unsigned SramNumWords = 256;
  localparam int unsigned RspTimeout   = 20;

  logic                 clk_i, rst_n_i, req_i, we_i, fetch_en_i;
  addr_t                addr_i;
  data_t                wdata_i, rdata_o;
  be_t                  be_i;
  logic [GpioCount-1:0] gpio_i, gpio_o, gpio_out_en_o, gpio_in_sync_o;
  logic                 gnt_o, rvalid_o, err_o, fetch_enable_o, gpio_irq_o;
  addr_t                boot_addr_o;

  int          err_count;
  int          check_count;
  logic [31:0] lfsr_q;
  data_t       sram_model [SramNumWords];
  data_t       exp_data_q [$];
  logic        exp_err_q [$];
  bit          exp_chk_q [$];
  data_t       rsp_data, d, boot_val, scratch_val;
  logic        rsp_err;
  bit          rsp_chk;
  be_t         b;
  int unsigned idx_list [8];
  logic [GpioCount-1:0] pin_val, dir_val, out_val;

  periph_subsystem dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Byte lanes with their enable set take the new data
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic bit is_unmapped(input addr_t a);
    bit in_sram, in_soc, in_gpio;
    in_sram = (a >= SramBaseAddr) && (a < SramBaseAddr + SramNumWords * 4);
    in_soc  = (a >= SocCtrlBaseAddr) && (a < SocCtrlBaseAddr + 32'h1000);
    in_gpio = (a >= GpioBaseAddr) && (a < GpioBaseAddr + 32'h1000);
    return !(in_sram || in_soc || in_gpio);
  endfunction

  task check_value(input string name, input data_t exp, input data_t act);
    check_count++;
    assert (act === exp) else begin
      err_count++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // Drive one request and queue its expected response
  task access(input logic we, input addr_t addr, input data_t wdata, input be_t be,
              input data_t exp_data);
    logic miss;
    miss = is_unmapped(addr);
    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    exp_data_q.push_back(miss ? ErrRspData : exp_data);
    exp_err_q.push_back(miss);
    exp_chk_q.push_back(miss || !we);
  endtask

  task go_idle;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task wait_responses;
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0 && cycles < RspTimeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_data_q.size() != 0) begin
      err_count++;
      $display("timeout at %0t: %0d responses never arrived", $time, exp_data_q.size());
      exp_data_q.delete();
      exp_err_q.delete();
      exp_chk_q.delete();
    end
  endtask

  task read_word(input addr_t addr, input data_t exp_data);
    access(1'b0, addr, '0, 4'hF, exp_data);
    go_idle();
    wait_responses();
  endtask

  task write_word(input addr_t addr, input data_t wdata);
    access(1'b1, addr, wdata, 4'hF, '0);
    go_idle();
    wait_responses();
  endtask

  task wait_sync_value(input logic [GpioCount-1:0] v);
    int cycles;
    cycles = 0;
    while (gpio_in_sync_o !== v && cycles < RspTimeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (gpio_in_sync_o !== v) begin
      err_count++;
      $display("timeout at %0t: gpio_in_sync_o never reached %h", $time, v);
    end
  endtask

  task wait_irq_high;
    int cycles;
    cycles = 0;
    while (gpio_irq_o !== 1'b1 && cycles < RspTimeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (gpio_irq_o !== 1'b1) begin
      err_count++;
      $display("timeout at %0t: gpio_irq_o never went high", $time);
    end
  endtask

  // ----------------------------------------------------------
  // Checkers
  // ----------------------------------------------------------
  a_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i) req_i |-> gnt_o)
    else begin
      err_count++;
      $display("grant missing for a request at %0t", $time);
    end

  // rvalid_o also stays low on idle cycles
  a_rsp_one_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o == $past(req_i && gnt_o))
    else begin
      err_count++;
      $display("rvalid_o not exactly one cycle after acceptance at %0t", $time);
    end

  a_sync_two_cycles : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gpio_in_sync_o == $past(gpio_i, 2))
    else begin
      err_count++;
      $display("gpio_in_sync_o did not follow gpio_i by two cycles at %0t", $time);
    end

  // Responses sampled mid-cycle in request order
  always @(negedge clk_i) begin
    if (rst_n_i && rvalid_o) begin
      if (exp_data_q.size() == 0) begin
        err_count++;
        $display("response at %0t with no request outstanding", $time);
      end else begin
        rsp_data = exp_data_q.pop_front();
        rsp_err  = exp_err_q.pop_front();
        rsp_chk  = exp_chk_q.pop_front();
        check_value("err_o", data_t'(rsp_err), data_t'(err_o));
        if (rsp_chk) check_value("rdata_o", rsp_data, rdata_o);
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    err_count   = 0;
    check_count = 0;
    lfsr_q      = 32'h90ee;
    rst_n_i     = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    fetch_en_i  = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    gpio_i      = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Reset values
    check_value("rvalid_o", 0, data_t'(rvalid_o));
    check_value("gpio_o", 0, data_t'(gpio_o));
    check_value("gpio_out_en_o", 0, data_t'(gpio_out_en_o));
    check_value("gpio_irq_o", 0, data_t'(gpio_irq_o));
    check_value("boot_addr_o", SramBaseAddr, boot_addr_o);
    check_value("fetch_enable_o", 0, data_t'(fetch_enable_o));
    @(posedge clk_i);
    #1;
    fetch_en_i = 1'b1;
    @(negedge clk_i);
    check_value("fetch_enable_o", 1, data_t'(fetch_enable_o));
    @(posedge clk_i);
    #1;
    fetch_en_i = 1'b0;
    repeat (4) @(posedge clk_i);
    check_value("fetch_enable_o", 0, data_t'(fetch_enable_o));

    // SRAM full writes, partial writes, then back-to-back reads
    for (int i = 0; i < 8; i++) begin
      idx_list[i] = rand_bits(8);
      d = rand_bits(32);
      sram_model[idx_list[i]] = d;
      access(1'b1, SramBaseAddr + idx_list[i] * 4, d, 4'hF, '0);
    end
    go_idle();
    wait_responses();
    for (int i = 0; i < 8; i++) begin
      d = rand_bits(32);
      b = be_t'(rand_bits(4));
      sram_model[idx_list[i]] = merge_bytes(sram_model[idx_list[i]], d, b);
      access(1'b1, SramBaseAddr + idx_list[i] * 4, d, b, '0);
    end
    go_idle();
    wait_responses();
    for (int i = 0; i < 8; i++) begin
      access(1'b0, SramBaseAddr + idx_list[i] * 4, '0, 4'hF, sram_model[idx_list[i]]);
    end
    go_idle();
    wait_responses();

    // Unmapped reads and writes, then SRAM again
    access(1'b0, 32'h2000_0000, '0, 4'hF, '0);
    access(1'b1, 32'h0300_1000, rand_bits(32), 4'hF, '0);
    access(1'b0, SramBaseAddr + SramNumWords * 4, '0, 4'hF, '0);
    access(1'b0, SramBaseAddr + idx_list[0] * 4, '0, 4'hF, sram_model[idx_list[0]]);
    go_idle();
    wait_responses();

    // SoC control
    boot_val = rand_bits(30) << 2;
    access(1'b1, SocCtrlBaseAddr, boot_val, 4'hF, '0);
    go_idle();
    check_value("boot_addr_o", boot_val, boot_addr_o);
    wait_responses();
    access(1'b1, SocCtrlBaseAddr + 4, 32'd1, 4'hF, '0);
    go_idle();
    check_value("fetch_enable_o", 1, data_t'(fetch_enable_o));
    wait_responses();
    scratch_val = rand_bits(32);
    write_word(SocCtrlBaseAddr + 8, scratch_val);
    read_word(SocCtrlBaseAddr, boot_val);
    read_word(SocCtrlBaseAddr + 4, 32'd1);
    read_word(SocCtrlBaseAddr + 8, scratch_val);

    // GPIO direction and output
    dir_val = GpioCount'(rand_bits(GpioCount));
    out_val = GpioCount'(rand_bits(GpioCount));
    access(1'b1, GpioBaseAddr, data_t'(dir_val), 4'hF, '0);
    access(1'b1, GpioBaseAddr + 4, data_t'(out_val), 4'hF, '0);
    go_idle();
    check_value("gpio_out_en_o", data_t'(dir_val), data_t'(gpio_out_en_o));
    check_value("gpio_o", data_t'(out_val), data_t'(gpio_o));
    wait_responses();

    // Input path while all interrupts are still disabled
    pin_val = 16'h1204;
    @(posedge clk_i);
    #1;
    gpio_i = pin_val;
    wait_sync_value(pin_val);
    read_word(GpioBaseAddr + 8, data_t'(pin_val));

    // Pin 3 enabled, pin 5 not
    write_word(GpioBaseAddr + 12, 32'h0000_0008);
    @(posedge clk_i);
    #1;
    gpio_i = pin_val | 16'h0028;
    wait_irq_high();
    read_word(GpioBaseAddr + 16, 32'h0000_0008);
    access(1'b1, GpioBaseAddr + 16, 32'h0000_0008, 4'hF, '0);
    go_idle();
    check_value("gpio_irq_o", 0, data_t'(gpio_irq_o));
    wait_responses();
    read_word(GpioBaseAddr + 16, 32'h0000_0000);

    repeat (4) @(posedge clk_i);
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== periph_subsystem.f ====
periph_pkg.sv
periph_demux.sv
periph_err_sbr.sv
sram_bank.sv
soc_ctrl_regs.sv
gpio_ctrl.sv
periph_subsystem.sv
tb_periph_subsystem.sv

// ==== Bender.yml ====
package:
  name: periph_subsystem

sources:
  - periph_pkg.sv
  - periph_demux.sv
  - periph_err_sbr.sv
  - sram_bank.sv
  - soc_ctrl_regs.sv
  - gpio_ctrl.sv
  - periph_subsystem.sv
  - target: test
    files:
      - tb_periph_subsystem.sv
